/* hdl/bmuPkg.sv */
/*
  Bit-manipulation decode package
  Opcode, funct7 and rs2 qualifier codes for the RV32 Zba, Zbb and Zbs
  instructions and the base shifts, the decode control-word layout and the
  two views of an instruction word.
*/
package bmuPkg;

  localparam int Xlen = 32;                         // RV32 only

  ////////////////////////////////////////////////////////////////////////////
  // opcodes and funct7 codes
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [6:0] OpReg      = 7'b0110011;   // R-type integer ops
  localparam logic [6:0] OpImm      = 7'b0010011;   // I-type integer ops

  localparam logic [6:0] ShAddF7    = 7'b0010000;   // sh1add/sh2add/sh3add
  localparam logic [6:0] MinMaxF7   = 7'b0000101;   // min/minu/max/maxu
  localparam logic [6:0] CountF7    = 7'b0110000;   // clz/ctz/cpop and sext
  localparam logic [6:0] OrcF7      = 7'b0010100;   // orc.b
  localparam logic [6:0] InvLogicF7 = 7'b0100000;   // andn/orn/xnor
  localparam logic [6:0] RotF7      = 7'b0110000;   // rol/ror/rori
  localparam logic [6:0] BclrF7     = 7'b0100100;   // bclr and bext
  localparam logic [6:0] BinvF7     = 7'b0110100;   // binv
  localparam logic [6:0] BsetF7     = 7'b0010100;   // bset
  localparam logic [6:0] ShiftF7    = 7'b0000000;   // sll/srl
  localparam logic [6:0] SraF7      = 7'b0100000;   // sra
  localparam logic [6:0] ZexthF7    = 7'b0000100;   // zext.h
  localparam logic [6:0] Rev8F7     = 7'b0110100;   // rev8 on RV32

  // rs2 field qualifiers
  localparam logic [4:0] Rs2Orc     = 5'b00111;     // orc.b
  localparam logic [4:0] Rs2Rev8    = 5'b11000;     // rev8
  localparam logic [3:0] Rs2Sext    = 4'b0010;      // upper four bits of sext.b/sext.h

  ////////////////////////////////////////////////////////////////////////////
  // select codes and control word
  ////////////////////////////////////////////////////////////////////////////
  localparam int AluSelWidth   = 3;
  localparam int BSelWidth     = 4;
  localparam int ZbbSelWidth   = 4;
  localparam int BAluCtrlWidth = 3;                 // rotate, mask, preshift

  localparam logic [BSelWidth-1:0] BSelectNone     = 4'b0000;   // plain ALU / shifter
  localparam logic [BSelWidth-1:0] BSelectAddShift = 4'b0001;   // shift-add, rotate, mask
  localparam logic [BSelWidth-1:0] BSelectBasic    = 4'b0010;   // zbb result mux

  localparam int CtrlWidth = AluSelWidth + BSelWidth + ZbbSelWidth + 6;   // 17

  // low index of each field, top field first
  localparam int CtrlPreShift = 0;
  localparam int CtrlMask     = 1;
  localparam int CtrlRotate   = 2;
  localparam int CtrlSubArith = 3;
  localparam int CtrlAluOp    = 4;
  localparam int CtrlSrcB     = 5;
  localparam int CtrlZbbSel   = 6;
  localparam int CtrlBSel     = CtrlZbbSel + ZbbSelWidth;
  localparam int CtrlAluSel   = CtrlBSel + BSelWidth;

  ////////////////////////////////////////////////////////////////////////////
  // instruction word views
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm12;                             // shamt plus upper code bits
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef union packed {
    rTypeT r;
    iTypeT i;
  } instrWordT;

  // flags are {srcB, aluOp, subArith, rotate, mask, preShift}
  function automatic logic [CtrlWidth-1:0] packCtrl(
    input logic [AluSelWidth-1:0] aluSel,
    input logic [BSelWidth-1:0]   bSel,
    input logic [ZbbSelWidth-1:0] zbbSel,
    input logic [5:0]             flags
  );
    logic [CtrlWidth-1:0] word;
    word = '0;
    word[CtrlAluSel +: AluSelWidth] = aluSel;
    word[CtrlBSel +: BSelWidth]     = bSel;
    word[CtrlZbbSel +: ZbbSelWidth] = zbbSel;
    word[CtrlSrcB:CtrlPreShift]     = flags;
    return word;
  endfunction

endpackage

/* hdl/bmuAddShiftDecode.sv */
/*
  Shift-add and base shift decoder
  Recognizes sh1add/sh2add/sh3add and the RV32 register and immediate
  shifts that run through the bit-manipulation shifter.
*/
`timescale 1ns/10ps

module bmuAddShiftDecode (
  input  bmuPkg::instrWordT               instrD,   // decode-stage instruction
  output logic [bmuPkg::CtrlWidth-1:0]    ctrl,     // zero unless hit
  output logic                            hit       // one of ours
);

  logic [6:0] op;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [6:0] immF7;                                  // upper imm bits of a shift
  logic       shamtHi;                                // shamt bit 5
  logic       shAdd;
  logic       regShift;
  logic       immShift;

  assign op      = instrD.r.opcode;
  assign f3      = instrD.r.funct3;
  assign f7      = instrD.r.funct7;
  assign immF7   = instrD.i.imm12[11:5];
  assign shamtHi = instrD.i.imm12[5];

  // sh1add 010, sh2add 100, sh3add 110
  assign shAdd = (op == bmuPkg::OpReg) && (f7 == bmuPkg::ShAddF7) &&
                 (f3 inside {3'b010, 3'b100, 3'b110});

  // sll 001, srl 101, sra 101 with bit 30
  assign regShift = (op == bmuPkg::OpReg) &&
                    (((f7 == bmuPkg::ShiftF7) && (f3 inside {3'b001, 3'b101})) ||
                     ((f7 == bmuPkg::SraF7) && (f3 == 3'b101)));

  // shift amounts of 32 and up do not exist on RV32
  assign immShift = (op == bmuPkg::OpImm) && !shamtHi &&
                    (((immF7[6:1] == bmuPkg::ShiftF7[6:1]) &&
                      (f3 inside {3'b001, 3'b101})) ||
                     ((immF7[6:1] == bmuPkg::SraF7[6:1]) && (f3 == 3'b101)));

  always_comb begin
    ctrl = '0;
    hit  = 1'b0;
    if (shAdd) begin
      hit  = 1'b1;
      ctrl = bmuPkg::packCtrl(3'b000, bmuPkg::BSelectAddShift, 4'b0000, 6'b010001);  // preshift
    end else if (regShift) begin
      hit  = 1'b1;
      ctrl = bmuPkg::packCtrl(3'b001, bmuPkg::BSelectNone, 4'b0000, 6'b010000);  // shifter
    end else if (immShift) begin
      hit  = 1'b1;
      ctrl = bmuPkg::packCtrl(3'b001, bmuPkg::BSelectNone, 4'b0000, 6'b110000);  // shamt as srcB
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  // every recognized word must steer the ALU select from the control word
  hitSetsAluOp: assert final (!hit || ctrl[bmuPkg::CtrlAluOp])
    else $error("shift decoder hit without aluOp");

endmodule

/* hdl/bmuBasicDecode.sv */
/*
  Zbb decoder
  Count, sign and zero extend, orc.b, min/max, rotate, inverted logic and
  rev8. The unary forms are qualified by the rs2 field.
*/
`timescale 1ns/10ps

module bmuBasicDecode (
  input  bmuPkg::instrWordT               instrD,   // decode-stage instruction
  output logic [bmuPkg::CtrlWidth-1:0]    ctrl,     // zero unless hit
  output logic                            hit       // one of ours
);

  logic [6:0] op;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [4:0] rs2;
  logic [6:0] immF7;                                  // rori upper bits
  logic       countSpace;                             // clz/ctz/cpop/sext encoding space

  assign op    = instrD.r.opcode;
  assign f3    = instrD.r.funct3;
  assign f7    = instrD.r.funct7;
  assign rs2   = instrD.r.rs2;
  assign immF7 = instrD.i.imm12[11:5];

  assign countSpace = (op == bmuPkg::OpImm) && (f7 == bmuPkg::CountF7) && (f3 == 3'b001);

  always_comb begin
    ctrl = '0;
    hit  = 1'b0;
    if (op == bmuPkg::OpImm) begin
      if (countSpace) begin
        if (rs2[4:1] == bmuPkg::Rs2Sext) begin            // sext.b, sext.h
          hit  = 1'b1;
          ctrl = bmuPkg::packCtrl(3'b000, bmuPkg::BSelectBasic, 4'b0001, 6'b110000);
        end else if (rs2 <= 5'd2) begin                   // clz, ctz, cpop
          hit  = 1'b1;
          ctrl = bmuPkg::packCtrl(3'b000, bmuPkg::BSelectBasic, 4'b0000, 6'b110000);
        end
      end else if ((f7 == bmuPkg::OrcF7) && (f3 == 3'b101) && (rs2 == bmuPkg::Rs2Orc)) begin
        hit  = 1'b1;                                      // orc.b
        ctrl = bmuPkg::packCtrl(3'b000, bmuPkg::BSelectBasic, 4'b0010, 6'b110000);
      end else if ((f7 == bmuPkg::Rev8F7) && (f3 == 3'b101) &&
                   (rs2 == bmuPkg::Rs2Rev8)) begin
        hit  = 1'b1;                                      // rev8 shares the byte mux
        ctrl = bmuPkg::packCtrl(3'b000, bmuPkg::BSelectBasic, 4'b0010, 6'b110000);
      end else if ((immF7 == bmuPkg::RotF7) && (f3 == 3'b101)) begin
        hit  = 1'b1;                                      // rori
        ctrl = bmuPkg::packCtrl(3'b001, bmuPkg::BSelectNone, 4'b0111, 6'b110100);
      end
    end else if (op == bmuPkg::OpReg) begin
      case (f7)
        bmuPkg::MinMaxF7: begin
          if (f3[2]) begin                                // 1x0 signed, 1x1 unsigned
            hit  = 1'b1;
            ctrl = bmuPkg::packCtrl(3'b000, bmuPkg::BSelectBasic,
                                    f3[1] ? 4'b0111 : 4'b0011, 6'b011000);  // max : min
          end
        end
        bmuPkg::ZexthF7: begin
          if (f3 == 3'b100) begin                         // zext.h
            hit  = 1'b1;
            ctrl = bmuPkg::packCtrl(3'b000, bmuPkg::BSelectBasic, 4'b0001, 6'b010000);
          end
        end
        bmuPkg::RotF7: begin
          if (f3 inside {3'b001, 3'b101}) begin           // rol, ror
            hit  = 1'b1;
            ctrl = bmuPkg::packCtrl(3'b001, bmuPkg::BSelectAddShift, 4'b0111, 6'b010100);
          end
        end
        bmuPkg::InvLogicF7: begin
          if (f3 inside {3'b100, 3'b110, 3'b111}) begin   // xnor, orn, andn
            hit  = 1'b1;
            ctrl = bmuPkg::packCtrl(f3, bmuPkg::BSelectAddShift, 4'b0111, 6'b011000);
          end
        end
        default: begin
          hit = 1'b0;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  // reserved rs2 values in the count space stay illegal
  countRs2Reserved: assert final (!(countSpace && (rs2 > 5'd2) &&
                                    (rs2[4:1] != bmuPkg::Rs2Sext)) || !hit)
    else $error("reserved count rs2 decoded as legal");

endmodule

/* hdl/bmuSingleBitDecode.sv */
/*
  Zbs decoder
  bclr, bext, binv and bset in register form and RV32 immediate form.
*/
`timescale 1ns/10ps

module bmuSingleBitDecode (
  input  bmuPkg::instrWordT               instrD,   // decode-stage instruction
  output logic [bmuPkg::CtrlWidth-1:0]    ctrl,     // zero unless hit
  output logic                            hit       // one of ours
);

  logic                          isReg;
  logic                          isImm;
  logic [6:0]                    upper;             // funct7 or imm12[11:5]
  logic [2:0]                    f3;
  logic [bmuPkg::AluSelWidth-1:0] aluSel;
  logic                          isClr;

  assign isReg = instrD.r.opcode == bmuPkg::OpReg;
  assign isImm = instrD.r.opcode == bmuPkg::OpImm;
  assign f3    = instrD.r.funct3;
  // RV32 immediate form has no shamt bit 5 so the code sits in all seven bits
  assign upper = instrD.i.imm12[11:5];              // same bits as funct7 in register form
  assign isClr = aluSel == 3'b111;                  // bclr inverts the mask

  always_comb begin
    aluSel = 3'b000;
    hit    = 1'b0;
    if (isReg || isImm) begin
      if ((upper == bmuPkg::BclrF7) && (f3 == 3'b001)) begin
        hit    = 1'b1;                              // bclr
        aluSel = 3'b111;
      end else if ((upper == bmuPkg::BclrF7) && (f3 == 3'b101)) begin
        hit    = 1'b1;                              // bext
        aluSel = 3'b101;
      end else if ((upper == bmuPkg::BinvF7) && (f3 == 3'b001)) begin
        hit    = 1'b1;                              // binv
        aluSel = 3'b100;
      end else if ((upper == bmuPkg::BsetF7) && (f3 == 3'b001)) begin
        hit    = 1'b1;                              // bset
        aluSel = 3'b110;
      end
    end
  end

  // flags {srcB, aluOp, subArith, rotate, mask, preShift}
  assign ctrl = hit ? bmuPkg::packCtrl(aluSel, bmuPkg::BSelectAddShift, 4'b0000,
                                       {isImm, 1'b1, isClr, 1'b0, 1'b1, 1'b0})
                    : '0;

endmodule

/* hdl/bmuCtrl.sv */
/*
  Bit-manipulation control unit
  Merges the shift-add, Zbb and Zbs decoders into the decode-stage controls
  and the ALU select, then carries unit select, Zbb select, ALU control and
  the active flag into execute through a stall/flush register.
*/
`timescale 1ns/10ps

module bmuCtrl (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [bmuPkg::Xlen-1:0]          instrD,         // decode-stage instruction
  input  logic                             aluOpD,         // regular ALU op from main decoder
  input  logic                             stallE,
  input  logic                             flushE,
  output logic                             bRegWriteD,
  output logic                             bAluSrcBD,      // immediate operand
  output logic                             bSubArithD,     // subtract / invert operand
  output logic                             illegalBitmanipInstrD,
  output logic [bmuPkg::AluSelWidth-1:0]   aluSelectD,
  output logic [bmuPkg::BSelWidth-1:0]     bSelectE,
  output logic [bmuPkg::ZbbSelWidth-1:0]   zbbSelectE,
  output logic [bmuPkg::BAluCtrlWidth-1:0] bAluControlE,   // rotate, mask, preshift
  output logic                             bmuActiveE
);

  bmuPkg::instrWordT                    instrWordD;
  logic [bmuPkg::CtrlWidth-1:0]         ctrlAddShift;
  logic [bmuPkg::CtrlWidth-1:0]         ctrlBasic;
  logic [bmuPkg::CtrlWidth-1:0]         ctrlSingleBit;
  logic                                 hitAddShift;
  logic                                 hitBasic;
  logic                                 hitSingleBit;
  logic [bmuPkg::CtrlWidth-1:0]         ctrlD;          // merged word
  logic                                 illegalD;
  logic                                 bAluOpD;
  logic [bmuPkg::AluSelWidth-1:0]       bAluSelD;
  logic [bmuPkg::BSelWidth-1:0]         bSelectD;
  logic [bmuPkg::ZbbSelWidth-1:0]       zbbSelectD;
  logic [bmuPkg::BAluCtrlWidth-1:0]     bAluControlD;

  assign instrWordD = instrD;

  ////////////////////////////////////////////////////////////////////////////
  // decoders
  ////////////////////////////////////////////////////////////////////////////
  bmuAddShiftDecode addShiftDec (
    .instrD (instrWordD),
    .ctrl   (ctrlAddShift),
    .hit    (hitAddShift)
  );

  bmuBasicDecode basicDec (
    .instrD (instrWordD),
    .ctrl   (ctrlBasic),
    .hit    (hitBasic)
  );

  bmuSingleBitDecode singleBitDec (
    .instrD (instrWordD),
    .ctrl   (ctrlSingleBit),
    .hit    (hitSingleBit)
  );

  // encodings are disjoint and a miss gives zero so OR is the merge
  assign ctrlD    = ctrlAddShift | ctrlBasic | ctrlSingleBit;
  assign illegalD = ~(hitAddShift | hitBasic | hitSingleBit);

  // field split
  assign bAluSelD     = ctrlD[bmuPkg::CtrlAluSel +: bmuPkg::AluSelWidth];
  assign bSelectD     = ctrlD[bmuPkg::CtrlBSel +: bmuPkg::BSelWidth];
  assign zbbSelectD   = ctrlD[bmuPkg::CtrlZbbSel +: bmuPkg::ZbbSelWidth];
  assign bAluOpD      = ctrlD[bmuPkg::CtrlAluOp];
  assign bAluControlD = {ctrlD[bmuPkg::CtrlRotate], ctrlD[bmuPkg::CtrlMask],
                         ctrlD[bmuPkg::CtrlPreShift]};

  assign bAluSrcBD             = ctrlD[bmuPkg::CtrlSrcB];
  assign bSubArithD            = ctrlD[bmuPkg::CtrlSubArith];
  assign illegalBitmanipInstrD = illegalD;
  assign bRegWriteD            = ~illegalD;

  // bmu select, else funct3 for IEU ops, else add
  assign aluSelectD = bAluOpD ? bAluSelD :
                      (aluOpD ? instrWordD.r.funct3 : '0);

  ////////////////////////////////////////////////////////////////////////////
  // execute-stage register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      bSelectE     <= '0;
      zbbSelectE   <= '0;
      bAluControlE <= '0;
      bmuActiveE   <= 1'b0;
    end else if (!stallE) begin                     // stall wins over flush
      if (flushE) begin
        bSelectE     <= '0;                         // bubble
        zbbSelectE   <= '0;
        bAluControlE <= '0;
        bmuActiveE   <= 1'b0;
      end else begin
        bSelectE     <= bSelectD;
        zbbSelectE   <= zbbSelectD;
        bAluControlE <= bAluControlD;
        bmuActiveE   <= ~illegalD;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  // decoders own disjoint encodings
  oneDecoderHit: assert property (@(posedge clk) disable iff (rst)
    $onehot0({hitAddShift, hitBasic, hitSingleBit}))
    else $error("more than one bmu decoder hit");

  // reset leaves execute idle
  idleAfterReset: assert property (@(posedge clk) rst |=> !bmuActiveE)
    else $error("bmuActiveE set after reset");

endmodule

/* tests/bmuRefModel.svh */
/*
  Reference decode for the bit-manipulation control unit
  Maps an instruction word to the expected decode and execute fields,
  row by row from the Zba, Zbb, Zbs and base shift encoding tables.
*/
`ifndef BMU_REF_MODEL_SVH
`define BMU_REF_MODEL_SVH

typedef struct packed {
  logic       legal;                                  // one of the kept instructions
  logic [2:0] aluSel;
  logic [3:0] bSel;
  logic [3:0] zbbSel;
  logic       srcB;
  logic       subArith;
  logic [2:0] aluCtrl;                                // rotate, mask, preshift
} expCtrlT;

function automatic expCtrlT refDecode(input logic [31:0] w);
  logic [6:0] op;
  logic [9:0] key;                                    // {funct7, funct3}
  logic [4:0] rs2;
  logic       imm;
  expCtrlT    e;
  op  = w[6:0];
  key = {w[31:25], w[14:12]};
  rs2 = w[24:20];
  imm = (op == 7'b0010011);
  e   = '0;
  if ((op == 7'b0110011) || imm) begin
    case (key)                                        // Zbs, both forms
      10'b0100100_001: e = {1'b1, 3'b111, 4'b0001, 4'b0000, imm, 1'b1, 3'b010};
      10'b0100100_101: e = {1'b1, 3'b101, 4'b0001, 4'b0000, imm, 1'b0, 3'b010};
      10'b0110100_001: e = {1'b1, 3'b100, 4'b0001, 4'b0000, imm, 1'b0, 3'b010};
      10'b0010100_001: e = {1'b1, 3'b110, 4'b0001, 4'b0000, imm, 1'b0, 3'b010};
      default: ;
    endcase
  end
  if (op == 7'b0110011) begin
    case (key)
      10'b0010000_010, 10'b0010000_100, 10'b0010000_110:                // shNadd
        e = {1'b1, 3'b000, 4'b0001, 4'b0000, 1'b0, 1'b0, 3'b001};
      10'b0000000_001, 10'b0000000_101, 10'b0100000_101:                // sll srl sra
        e = {1'b1, 3'b001, 4'b0000, 4'b0000, 1'b0, 1'b0, 3'b000};
      10'b0100000_111:                                                  // andn
        e = {1'b1, 3'b111, 4'b0001, 4'b0111, 1'b0, 1'b1, 3'b000};
      10'b0100000_110:                                                  // orn
        e = {1'b1, 3'b110, 4'b0001, 4'b0111, 1'b0, 1'b1, 3'b000};
      10'b0100000_100:                                                  // xnor
        e = {1'b1, 3'b100, 4'b0001, 4'b0111, 1'b0, 1'b1, 3'b000};
      10'b0000101_100, 10'b0000101_101:                                 // min minu
        e = {1'b1, 3'b000, 4'b0010, 4'b0011, 1'b0, 1'b1, 3'b000};
      10'b0000101_110, 10'b0000101_111:                                 // max maxu
        e = {1'b1, 3'b000, 4'b0010, 4'b0111, 1'b0, 1'b1, 3'b000};
      10'b0000100_100:                                                  // zext.h
        e = {1'b1, 3'b000, 4'b0010, 4'b0001, 1'b0, 1'b0, 3'b000};
      10'b0110000_001, 10'b0110000_101:                                 // rol ror
        e = {1'b1, 3'b001, 4'b0001, 4'b0111, 1'b0, 1'b0, 3'b100};
      default: ;
    endcase
  end else if (imm) begin
    case (key)
      10'b0000000_001, 10'b0000000_101, 10'b0100000_101:                // shamt bit 5 clear
        e = {1'b1, 3'b001, 4'b0000, 4'b0000, 1'b1, 1'b0, 3'b000};
      10'b0110000_001: begin
        if (rs2[4:1] == 4'b0010)                                        // sext.b sext.h
          e = {1'b1, 3'b000, 4'b0010, 4'b0001, 1'b1, 1'b0, 3'b000};
        else if (rs2 <= 5'd2)                                           // clz ctz cpop
          e = {1'b1, 3'b000, 4'b0010, 4'b0000, 1'b1, 1'b0, 3'b000};
      end
      10'b0110000_101:                                                  // rori
        e = {1'b1, 3'b001, 4'b0000, 4'b0111, 1'b1, 1'b0, 3'b100};
      10'b0010100_101, 10'b0110100_101: begin                           // orc.b rev8
        if ((key[9:3] == 7'b0010100 && rs2 == 5'd7) ||
            (key[9:3] == 7'b0110100 && rs2 == 5'd24))
          e = {1'b1, 3'b000, 4'b0010, 4'b0010, 1'b1, 1'b0, 3'b000};
      end
      default: ;
    endcase
  end
  return e;
endfunction

`endif

/* tests/bmuCtrlTb.sv */
/*
  Testbench for the bit-manipulation control unit
  Directed tests for reset, Zba and shifts, Zbb, Zbs, the ALU select
  fallback and the stall/flush register, then seeded random words checked
  against the reference decode.
*/
`timescale 1ns/10ps

module bmuCtrlTb;

  `include "bmuRefModel.svh"

  localparam logic [6:0] OpR = 7'b0110011;
  localparam logic [6:0] OpI = 7'b0010011;
  // tests take about 530 cycles
  localparam int CycleLimit = 2000;

  logic        clk;
  logic        rst;
  logic [31:0] instrD;
  logic        aluOpD;
  logic        stallE;
  logic        flushE;
  logic        bRegWriteD;
  logic        bAluSrcBD;
  logic        bSubArithD;
  logic        illegalBitmanipInstrD;
  logic [2:0]  aluSelectD;
  logic [3:0]  bSelectE;
  logic [3:0]  zbbSelectE;
  logic [2:0]  bAluControlE;
  logic        bmuActiveE;
  int          cycleCount = 0;
  integer      seed;
  logic [6:0]  f7Codes [10] = '{7'b0010000, 7'b0000101, 7'b0110000, 7'b0010100,
                                7'b0100000, 7'b0100100, 7'b0110100, 7'b0000000,
                                7'b0000100, 7'b0000001};   // kept codes plus one bad shift

  bmuCtrl dut0 (
    .clk                   (clk),
    .rst                   (rst),
    .instrD                (instrD),
    .aluOpD                (aluOpD),
    .stallE                (stallE),
    .flushE                (flushE),
    .bRegWriteD            (bRegWriteD),
    .bAluSrcBD             (bAluSrcBD),
    .bSubArithD            (bSubArithD),
    .illegalBitmanipInstrD (illegalBitmanipInstrD),
    .aluSelectD            (aluSelectD),
    .bSelectE              (bSelectE),
    .zbbSelectE            (zbbSelectE),
    .bAluControlE          (bAluControlE),
    .bmuActiveE            (bmuActiveE)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                           // 20 ns period
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == CycleLimit) begin
      $display("Timeout: tests still running after %0d cycles", CycleLimit);
      $display("Done: errors found");
      $fatal(1, "run stopped by timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [2:0] f3, input logic [6:0] op);
    return {f7, rs2, 5'd11, f3, 5'd13, op};           // rs2 doubles as shamt / unary code
  endfunction

  task automatic checkEq(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Done: errors found");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic checkDecode(input logic [31:0] w, input logic aop, input expCtrlT e);
    logic [2:0] expSel;
    expSel = e.legal ? e.aluSel : (aop ? w[14:12] : 3'b000);   // funct3 fallback
    checkEq("illegalBitmanipInstrD", 32'(illegalBitmanipInstrD), 32'(!e.legal));
    checkEq("bRegWriteD", 32'(bRegWriteD), 32'(e.legal));
    checkEq("bAluSrcBD", 32'(bAluSrcBD), 32'(e.srcB));
    checkEq("bSubArithD", 32'(bSubArithD), 32'(e.subArith));
    checkEq("aluSelectD", 32'(aluSelectD), 32'(expSel));
  endtask

  task automatic checkExecute(input expCtrlT e);
    checkEq("bSelectE", 32'(bSelectE), 32'(e.bSel));
    checkEq("zbbSelectE", 32'(zbbSelectE), 32'(e.zbbSel));
    checkEq("bAluControlE", 32'(bAluControlE), 32'(e.aluCtrl));
    checkEq("bmuActiveE", 32'(bmuActiveE), 32'(e.legal));
  endtask

  // decode checked mid-cycle, execute one edge later
  task automatic applyWord(input logic [31:0] w, input logic aop);
    expCtrlT e;
    e = refDecode(w);
    @(posedge clk);
    instrD <= w;
    aluOpD <= aop;
    @(negedge clk);
    checkDecode(w, aop, e);
    @(posedge clk);
    @(negedge clk);
    checkExecute(e);
  endtask

  task automatic stepAndCheckExecute(input int n, input expCtrlT e);
    repeat (n) begin
      @(posedge clk);
      @(negedge clk);
      checkExecute(e);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic resetTest();
    repeat (10) begin
      @(negedge clk);
      checkExecute('0);                               // legal word on instrD, still idle
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkExecute('0);                                 // release edge still saw rst
  endtask

  task automatic addShiftTest();
    applyWord(encodeR(7'b0010000, 5'd2, 3'b010, OpR), 1'b0);   // sh1add
    applyWord(encodeR(7'b0010000, 5'd2, 3'b100, OpR), 1'b0);   // sh2add
    applyWord(encodeR(7'b0010000, 5'd2, 3'b110, OpR), 1'b0);   // sh3add
    applyWord(encodeR(7'b0000000, 5'd3, 3'b001, OpR), 1'b0);   // sll
    applyWord(encodeR(7'b0000000, 5'd3, 3'b101, OpR), 1'b0);   // srl
    applyWord(encodeR(7'b0100000, 5'd3, 3'b101, OpR), 1'b0);   // sra
    applyWord(encodeR(7'b0000000, 5'd5, 3'b001, OpI), 1'b0);   // slli
    applyWord(encodeR(7'b0000000, 5'd31, 3'b101, OpI), 1'b0);  // srli
    applyWord(encodeR(7'b0100000, 5'd7, 3'b101, OpI), 1'b0);   // srai
    applyWord(encodeR(7'b0000001, 5'd4, 3'b001, OpI), 1'b0);   // slli, shamt 36
    checkEq("illegalBitmanipInstrD", 32'(illegalBitmanipInstrD), 32'd1);
  endtask

  task automatic basicTest();
    applyWord(encodeR(7'b0110000, 5'd0, 3'b001, OpI), 1'b0);   // clz
    applyWord(encodeR(7'b0110000, 5'd1, 3'b001, OpI), 1'b0);   // ctz
    applyWord(encodeR(7'b0110000, 5'd2, 3'b001, OpI), 1'b0);   // cpop
    applyWord(encodeR(7'b0110000, 5'd4, 3'b001, OpI), 1'b0);   // sext.b
    applyWord(encodeR(7'b0110000, 5'd5, 3'b001, OpI), 1'b0);   // sext.h
    applyWord(encodeR(7'b0000100, 5'd0, 3'b100, OpR), 1'b0);   // zext.h
    applyWord(encodeR(7'b0010100, 5'd7, 3'b101, OpI), 1'b0);   // orc.b
    applyWord(encodeR(7'b0110100, 5'd24, 3'b101, OpI), 1'b0);  // rev8
    applyWord(encodeR(7'b0000101, 5'd6, 3'b100, OpR), 1'b0);   // min
    applyWord(encodeR(7'b0000101, 5'd6, 3'b101, OpR), 1'b0);   // minu
    applyWord(encodeR(7'b0000101, 5'd6, 3'b110, OpR), 1'b0);   // max
    applyWord(encodeR(7'b0000101, 5'd6, 3'b111, OpR), 1'b0);   // maxu
    applyWord(encodeR(7'b0110000, 5'd6, 3'b001, OpR), 1'b0);   // rol
    applyWord(encodeR(7'b0110000, 5'd6, 3'b101, OpR), 1'b0);   // ror
    applyWord(encodeR(7'b0110000, 5'd9, 3'b101, OpI), 1'b0);   // rori
    applyWord(encodeR(7'b0100000, 5'd6, 3'b111, OpR), 1'b0);   // andn
    applyWord(encodeR(7'b0100000, 5'd6, 3'b110, OpR), 1'b0);   // orn
    applyWord(encodeR(7'b0100000, 5'd6, 3'b100, OpR), 1'b0);   // xnor
    applyWord(encodeR(7'b0110000, 5'd3, 3'b001, OpI), 1'b0);   // reserved count code
    checkEq("illegalBitmanipInstrD", 32'(illegalBitmanipInstrD), 32'd1);
    applyWord(encodeR(7'b0010100, 5'd6, 3'b101, OpI), 1'b0);   // orc with wrong rs2
    checkEq("illegalBitmanipInstrD", 32'(illegalBitmanipInstrD), 32'd1);
  endtask

  task automatic singleBitTest();
    applyWord(encodeR(7'b0100100, 5'd8, 3'b001, OpR), 1'b0);   // bclr
    applyWord(encodeR(7'b0100100, 5'd8, 3'b101, OpR), 1'b0);   // bext
    applyWord(encodeR(7'b0110100, 5'd8, 3'b001, OpR), 1'b0);   // binv
    applyWord(encodeR(7'b0010100, 5'd8, 3'b001, OpR), 1'b0);   // bset
    applyWord(encodeR(7'b0100100, 5'd17, 3'b001, OpI), 1'b0);  // bclri
    applyWord(encodeR(7'b0100100, 5'd17, 3'b101, OpI), 1'b0);  // bexti
    applyWord(encodeR(7'b0110100, 5'd17, 3'b001, OpI), 1'b0);  // binvi
    applyWord(encodeR(7'b0010100, 5'd17, 3'b001, OpI), 1'b0);  // bseti
  endtask

  task automatic fallbackTest();
    applyWord(encodeR(7'b0000000, 5'd2, 3'b111, OpR), 1'b1);   // and, funct3 passes
    applyWord(encodeR(7'b0000000, 5'd2, 3'b111, OpR), 1'b0);
    applyWord(encodeR(7'b0000000, 5'd1, 3'b100, OpI), 1'b1);   // xori
    applyWord(encodeR(7'b0000000, 5'd1, 3'b100, OpI), 1'b0);
    applyWord(encodeR(7'b0000000, 5'd0, 3'b010, 7'b0000011), 1'b1);  // lw
  endtask

  task automatic pipelineTest();
    logic [31:0] wordA;
    logic [31:0] wordB;
    wordA = encodeR(7'b0110000, 5'd9, 3'b101, OpI);   // rori
    wordB = encodeR(7'b0010000, 5'd2, 3'b100, OpR);   // sh2add
    applyWord(wordA, 1'b0);
    @(posedge clk);
    stallE <= 1'b1;
    instrD <= wordB;
    @(negedge clk);
    checkExecute(refDecode(wordA));                   // that edge reloaded A
    stepAndCheckExecute(3, refDecode(wordA));         // held under stall
    @(posedge clk);
    flushE <= 1'b1;
    @(negedge clk);
    checkExecute(refDecode(wordA));
    stepAndCheckExecute(3, refDecode(wordA));         // stall beats flush
    @(posedge clk);
    stallE <= 1'b0;
    @(negedge clk);
    checkExecute(refDecode(wordA));
    stepAndCheckExecute(1, '0);                       // flush alone clears
    @(posedge clk);
    flushE <= 1'b0;
    @(negedge clk);
    checkExecute('0);
    stepAndCheckExecute(1, refDecode(wordB));         // next word flows again
  endtask

  task automatic randomTest();
    logic [31:0] w;
    logic [31:0] sel;
    repeat (200) begin
      w   = $random(seed);
      sel = $random(seed);
      w[6:0] = sel[0] ? OpR : OpI;
      if (sel[1])
        w[31:25] = f7Codes[sel[7:4] % 4'd10];         // steer toward real encodings
      applyWord(w, sel[2]);
    end
  endtask

  initial begin
    seed   = 32'h5f5a0414;
    rst    = 1'b1;
    instrD = encodeR(7'b0010000, 5'd2, 3'b010, OpR);  // legal word under reset
    aluOpD = 1'b0;
    stallE = 1'b0;
    flushE = 1'b0;
    resetTest();
    addShiftTest();
    basicTest();
    singleBitTest();
    fallbackTest();
    pipelineTest();
    randomTest();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* src.f */
+incdir+tests
hdl/bmuPkg.sv
hdl/bmuAddShiftDecode.sv
hdl/bmuBasicDecode.sv
hdl/bmuSingleBitDecode.sv
hdl/bmuCtrl.sv
tests/bmuCtrlTb.sv

/* Bender.yml */
package:
  name: bmu_ctrl

sources:
  - files:
      - hdl/bmuPkg.sv
      - hdl/bmuAddShiftDecode.sv
      - hdl/bmuBasicDecode.sv
      - hdl/bmuSingleBitDecode.sv
      - hdl/bmuCtrl.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/bmuCtrlTb.sv
